// ==== all.f ====
rtl/rename_pkg.sv
rtl/rename_rat.sv
rtl/rename_operand_decoder.sv
rtl/rename_allocator.sv
rtl/rename_slot.sv
rtl/rename_stage.sv
tb/tb_clock_gen.sv
tb/tb_rename_stage.sv

// ==== Makefile ====
# Verilator build and run of the rename stage testbench
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_rename_stage -Mdir obj_dir
	./obj_dir/Vtb_rename_stage | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_rename_stage.sv ====
/* Random testbench for the rename stage with a reference model of RAT, done flags and pool.
   Frees only old aliases whose writer completed; frees are held for a while after group 100. */
`default_nettype none

module tb_rename_stage;

    localparam int N_GROUPS    = 400;
    localparam int TOTAL_SLOTS = 4 * N_GROUPS;
    localparam int CYCLE_LIMIT = N_GROUPS * 25;
    localparam int HOLD_START  = 100;

    logic         clk;
    logic         rst;
    logic [95:0]  group_ops;
    logic         group_valid;
    logic         group_ready;
    logic [19:0]  rob_tags;
    logic [167:0] renamed_ops;
    logic [19:0]  renamed_old_alias;
    logic [3:0]   renamed_valid;
    logic [3:0]   renamed_ready;
    logic [19:0]  cmplt_phys;
    logic [3:0]   cmplt_valid;
    logic [19:0]  free_phys;
    logic [3:0]   free_valid;

    // reference model
    logic [4:0]   m_alias [10];
    logic         m_done  [32];
    logic         m_pool  [32];
    logic         m_grp_full = 1'b0;
    logic [95:0]  m_grp_ops = '0;
    logic [19:0]  m_grp_tags = '0;
    logic [41:0]  exp_ops [4];
    logic [4:0]   exp_old [4];
    logic         exp_imm [4];
    logic [3:0]   exp_pending = '0;
    int           outstanding [$];
    int           free_cand [$];

    int    seed = 10;
    int    cycle = 0;
    int    moved = 0;
    int    dut_moved = 0;
    int    accepted = 0;
    int    renamed_groups = 0;
    int    sent = 0;
    int    stall_cycles = 0;
    logic  took = 1'b0;
    logic  prev_stall = 1'b0;
    logic  hold_frees = 1'b0;
    logic  hold_done = 1'b0;
    logic  first_pending = 1'b0;
    logic  timed_out = 1'b0;
    int    checks [6] = '{default: 0};
    int    errs [6] = '{default: 0};
    string test_names [6] = '{"reset state", "allocation and aliasing", "ready bits",
                              "immediate form", "back-pressure", "pool exhaustion"};

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    rename_stage i_rename_stage (
        .clk               (clk),
        .rst               (rst),
        .group_ops         (group_ops),
        .group_valid       (group_valid),
        .group_ready       (group_ready),
        .rob_tags          (rob_tags),
        .renamed_ops       (renamed_ops),
        .renamed_old_alias (renamed_old_alias),
        .renamed_valid     (renamed_valid),
        .renamed_ready     (renamed_ready),
        .cmplt_phys        (cmplt_phys),
        .cmplt_valid       (cmplt_valid),
        .free_phys         (free_phys),
        .free_valid        (free_valid)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic completes_now(input logic [4:0] r);
        for (int i = 0; i < 4; i++) begin
            if (cmplt_valid[i] && cmplt_phys[i*5 +: 5] == r) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int pool_count();
        int n;
        n = 0;
        for (int i = 2; i < 32; i++) begin
            n += int'(m_pool[i]);
        end
        return n;
    endfunction

    function automatic logic [4:0] lowest_free();
        for (int i = 2; i < 32; i++) begin
            if (m_pool[i]) begin
                return 5'(i);
            end
        end
        return 5'd0;
    endfunction

    // first old alias whose writer has completed, or -1
    function automatic int find_free_candidate();
        for (int j = 0; j < free_cand.size(); j++) begin
            if (m_done[free_cand[j]]) begin
                return j;
            end
        end
        return -1;
    endfunction

    task automatic check_val(input int cat, input string name, input logic [41:0] got,
                             input logic [41:0] exp);
        checks[cat]++;
        if (got !== exp) begin
            errs[cat]++;
            $display("[ERROR] cycle %0d %s: got %0h expected %0h", cycle, name, got, exp);
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %0d checks, %0d errors, %s", t + 1, test_names[t], checks[t],
                 errs[t], errs[t] == 0 ? "ok" : "failed");
    endtask

    task automatic check_outputs();
        logic [41:0] got;
        logic [41:0] e;
        int          cb;
        int          cr;
        check_val(prev_stall ? 5 : 4, "renamed_valid", renamed_valid, exp_pending);
        for (int k = 0; k < 4; k++) begin
            got = renamed_ops[k*42 +: 42];
            e   = exp_ops[k];
            cb  = exp_imm[k] ? 3 : 1;
            cr  = exp_imm[k] ? 3 : 2;
            if (exp_pending[k]) begin
                check_val(1, $sformatf("slot %0d arch_dst", k), got[41:38], e[41:38]);
                check_val(1, $sformatf("slot %0d opcode", k), got[37:34], e[37:34]);
                check_val(1, $sformatf("slot %0d rob_tag", k), got[33:29], e[33:29]);
                check_val(1, $sformatf("slot %0d dst_phys", k), got[28:24], e[28:24]);
                check_val(1, $sformatf("slot %0d src_a_phys", k), got[23:19], e[23:19]);
                check_val(2, $sformatf("slot %0d src_a_ready", k), got[18], e[18]);
                check_val(cb, $sformatf("slot %0d src_b_phys", k), got[17:13], e[17:13]);
                check_val(cr, $sformatf("slot %0d src_b_ready", k), got[12], e[12]);
                check_val(3, $sformatf("slot %0d imm", k), got[11:0], e[11:0]);
                check_val(1, $sformatf("slot %0d renamed_old_alias", k),
                          renamed_old_alias[k*5 +: 5], exp_old[k]);
            end
            // first group uses no source written inside it
            if (first_pending) begin
                check_val(0, $sformatf("slot %0d first dst_phys", k), got[28:24], 42'(2 + k));
                check_val(0, $sformatf("slot %0d first src_a_phys", k), got[23:19], 42'd0);
                check_val(0, $sformatf("slot %0d first src_a_ready", k), got[18], 42'd1);
                check_val(0, $sformatf("slot %0d first src_b_phys", k), got[17:13], 42'd0);
                check_val(0, $sformatf("slot %0d first src_b_ready", k), got[12], 42'd1);
            end
        end
        if (first_pending) begin
            first_pending = 1'b0;
            report_test(0);
        end
    endtask

    // model of the edge that follows, from the inputs and outputs settled now
    task automatic step_model();
        logic [3:0]  pn;
        logic        rename;
        logic        ready_exp;
        logic [23:0] op;
        logic [4:0]  pa;
        logic [4:0]  pb;
        logic [4:0]  p;
        logic        rb;
        logic [11:0] imm;
        check_outputs();
        pn        = exp_pending & ~renamed_ready;
        rename    = m_grp_full && pn == 4'b0 && pool_count() >= 4;
        ready_exp = !m_grp_full || rename;
        check_val(4, "group_ready", group_ready, ready_exp);
        prev_stall = m_grp_full && pn == 4'b0 && !rename;
        if (prev_stall && hold_frees) begin
            stall_cycles++;
        end
        for (int k = 0; k < 4; k++) begin
            moved += int'(exp_pending[k] && renamed_ready[k]);
            dut_moved += int'(renamed_valid[k] && renamed_ready[k]);
        end
        if (rename) begin
            for (int k = 0; k < 4; k++) begin
                op = m_grp_ops[k*24 +: 24];
                pa = m_alias[op[15:12]];
                exp_imm[k] = op[23];
                pb  = op[23] ? 5'd0 : m_alias[op[11:8]];
                rb  = m_done[pb] || completes_now(pb) || pb == 5'd0;
                imm = op[23] ? op[11:0] : 12'd0;
                exp_old[k] = m_alias[op[19:16]];
                p = lowest_free();
                m_pool[p] = 1'b0;
                m_done[p] = 1'b0;
                m_alias[op[19:16]] = p;
                exp_ops[k] = {op[19:16], op[23:20], m_grp_tags[k*5 +: 5], p, pa,
                              m_done[pa] || completes_now(pa) || pa == 5'd0, pb, rb, imm};
                outstanding.push_back(int'(p));
                if (exp_old[k] >= 5'd2) begin
                    free_cand.push_back(int'(exp_old[k]));
                end
            end
            renamed_groups++;
            first_pending = (renamed_groups == 1);
        end
        exp_pending = rename ? 4'hf : pn;
        for (int i = 0; i < 4; i++) begin
            if (cmplt_valid[i]) begin
                m_done[cmplt_phys[i*5 +: 5]] = 1'b1;
            end
            if (free_valid[i] && free_phys[i*5 +: 5] >= 5'd2) begin
                m_pool[free_phys[i*5 +: 5]] = 1'b1;
            end
        end
        accepted += int'(group_valid && group_ready);
        took = group_valid && ready_exp;
        if (took) begin
            m_grp_full = 1'b1;
            m_grp_ops  = group_ops;
            m_grp_tags = rob_tags;
        end else if (rename) begin
            m_grp_full = 1'b0;
        end
    endtask

    task automatic make_group(input int g, output logic [95:0] ops, output logic [19:0] tags);
        logic [23:0] op;
        for (int k = 0; k < 4; k++) begin
            op[23:20] = 4'(rand_below(16));
            op[19:16] = (g == 0) ? 4'(k) : 4'(rand_below(10));
            op[15:12] = (g == 0) ? 4'(4 + rand_below(6)) : 4'(rand_below(10));
            op[11:8]  = (g == 0) ? 4'(4 + rand_below(6)) : 4'(rand_below(10));
            op[7:0]   = 8'(rand_below(256));
            ops[k*24 +: 24] = op;
            tags[k*5 +: 5]  = 5'((g * 4 + k) % 32);
        end
    endtask

    task automatic drive_inputs();
        logic [95:0] ops;
        logic [19:0] tags;
        logic [19:0] cp;
        logic [3:0]  cv;
        logic [19:0] fp;
        logic [3:0]  fv;
        logic [3:0]  rdy;
        logic        gv;
        int          idx;
        sent += int'(took);
        gv   = group_valid && !took;
        ops  = group_ops;
        tags = rob_tags;
        if (!gv && sent < N_GROUPS && rand_below(100) < 80) begin
            make_group(sent, ops, tags);
            gv = 1'b1;
        end
        if (accepted >= HOLD_START && !hold_done) begin
            hold_frees = 1'b1;
        end
        if (hold_frees && stall_cycles >= 8) begin
            hold_frees = 1'b0;
            hold_done  = 1'b1;
        end
        cp = '0;
        cv = '0;
        fp = '0;
        fv = '0;
        for (int i = 0; i < 4; i++) begin
            rdy[i] = rand_below(100) < 60;
            if (outstanding.size() > 0 && rand_below(2) == 0) begin
                idx = rand_below(outstanding.size());
                cp[i*5 +: 5] = 5'(outstanding[idx]);
                cv[i] = 1'b1;
                outstanding.delete(idx);
            end
            idx = find_free_candidate();
            if (!hold_frees && idx >= 0 && rand_below(2) == 0) begin
                fp[i*5 +: 5] = 5'(free_cand[idx]);
                fv[i] = 1'b1;
                free_cand.delete(idx);
            end
        end
        group_valid   <= gv;
        group_ops     <= ops;
        rob_tags      <= tags;
        renamed_ready <= rdy;
        cmplt_phys    <= cp;
        cmplt_valid   <= cv;
        free_phys     <= fp;
        free_valid    <= fv;
    endtask

    initial begin
        group_ops     = '0;
        group_valid   = 1'b0;
        rob_tags      = '0;
        renamed_ready = '0;
        cmplt_phys    = '0;
        cmplt_valid   = '0;
        free_phys     = '0;
        free_valid    = '0;
        for (int i = 0; i < 32; i++) begin
            m_done[i] = 1'b1;
            m_pool[i] = (i >= 2);
        end
        for (int i = 0; i < 10; i++) begin
            m_alias[i] = 5'd0;
        end
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        check_val(0, "group_ready after reset", group_ready, 42'd1);
        check_val(0, "renamed_valid after reset", renamed_valid, 42'd0);
        while (moved < TOTAL_SLOTS && !timed_out) begin
            cycle++;
            if (cycle > CYCLE_LIMIT) begin
                timed_out = 1'b1;
            end else begin
                step_model();
                @(posedge clk);
                drive_inputs();
                @(negedge clk);
            end
        end
        if (timed_out) begin
            $display("timeout: %0d of %0d slots moved within %0d cycles", moved, TOTAL_SLOTS,
                     CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
        end else begin
            check_val(4, "moved slots", dut_moved, TOTAL_SLOTS);
            check_val(4, "accepted groups", accepted, N_GROUPS);
            checks[5]++;
            if (stall_cycles == 0) begin
                errs[5]++;
                $display("pool never ran short while frees were held");
            end
            for (int t = 1; t < 6; t++) begin
                report_test(t);
            end
            $display("summary: %0d checks, %0d errors, %0d groups, %0d slots moved",
                     checks.sum(), errs.sum(), renamed_groups, dut_moved);
            if (errs.sum() == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
/* Clock with a period of 40 time units and an active-high reset held for the first
   five rising edges. */
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== rtl/rename_stage.sv ====
/* Rename stage top. ROB tags are sampled with the group; a group renames only when all four
   slots get a register and the output buffer is free. Frees of registers 0 and 1 are dropped. */
`default_nettype none

module rename_stage (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  logic [rename_pkg::RENAME_WIDTH*rename_pkg::MICRO_OP_W-1:0]  group_ops,
    input  logic                                                        group_valid,
    output logic                                                        group_ready,
    input  logic [rename_pkg::RENAME_WIDTH*rename_pkg::ROB_TAG_W-1:0]   rob_tags,
    output logic [rename_pkg::RENAME_WIDTH*rename_pkg::RENAMED_OP_W-1:0] renamed_ops,
    output logic [rename_pkg::RENAME_WIDTH*rename_pkg::PR_ADDR_W-1:0]   renamed_old_alias,
    output logic [rename_pkg::RENAME_WIDTH-1:0]                         renamed_valid,
    input  logic [rename_pkg::RENAME_WIDTH-1:0]                         renamed_ready,
    input  logic [rename_pkg::N_CMPLT*rename_pkg::PR_ADDR_W-1:0]        cmplt_phys,
    input  logic [rename_pkg::N_CMPLT-1:0]                              cmplt_valid,
    input  logic [rename_pkg::N_FREE*rename_pkg::PR_ADDR_W-1:0]         free_phys,
    input  logic [rename_pkg::N_FREE-1:0]                               free_valid
);

    import rename_pkg::*;

    // group register
    logic [RENAME_WIDTH*MICRO_OP_W-1:0]   grp_ops_q;
    logic [RENAME_WIDTH*ROB_TAG_W-1:0]    grp_tags_q;
    logic                                 grp_valid_q;

    logic [POOL_W-1:0]                    pool_q;
    logic [PHYS_REGS-1:0]                 pool_view;
    logic [POOL_W-1:0]                    pool_next;
    logic [ALIAS_W-1:0]                   alias_cur;
    logic [ALIAS_W-1:0]                   alias_next;
    logic [PHYS_REGS-1:0]                 done_cur;
    logic [PHYS_REGS-1:0]                 done_next;

    // element k feeds slot k, the last one holds the whole group's result
    logic [POOL_W-1:0]                    pool_chain  [RENAME_WIDTH+1];
    logic [ALIAS_W-1:0]                   alias_chain [RENAME_WIDTH+1];
    logic [PHYS_REGS-1:0]                 done_chain  [RENAME_WIDTH+1];
    logic [RENAME_WIDTH:0]                valid_chain;

    logic [RENAME_WIDTH*RENAMED_OP_W-1:0] slot_ops;
    logic [RENAME_WIDTH*PR_ADDR_W-1:0]    slot_old;

    // output buffer
    logic [RENAME_WIDTH*RENAMED_OP_W-1:0] out_ops_q;
    logic [RENAME_WIDTH*PR_ADDR_W-1:0]    out_old_q;
    logic [RENAME_WIDTH-1:0]              out_pending_q;
    logic [RENAME_WIDTH-1:0]              pending_next;

    logic                                 do_rename;
    logic                                 group_take;

    rename_rat i_rat (
        .clk        (clk),
        .rst        (rst),
        .alias_next (alias_next),
        .done_next  (done_next),
        .alias_cur  (alias_cur),
        .done_cur   (done_cur)
    );

    assign pool_chain[0]  = pool_q;
    assign alias_chain[0] = alias_cur;
    assign done_chain[0]  = done_cur;
    assign valid_chain[0] = grp_valid_q;

    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : g_slot
        rename_slot i_slot (
            .op          (grp_ops_q[k*MICRO_OP_W +: MICRO_OP_W]),
            .rob_tag     (grp_tags_q[k*ROB_TAG_W +: ROB_TAG_W]),
            .pool_in     (pool_chain[k]),
            .alias_in    (alias_chain[k]),
            .done_in     (done_chain[k]),
            .prev_valid  (valid_chain[k]),
            .cmplt_phys  (cmplt_phys),
            .cmplt_valid (cmplt_valid),
            .pool_out    (pool_chain[k+1]),
            .alias_out   (alias_chain[k+1]),
            .done_out    (done_chain[k+1]),
            .renamed_op  (slot_ops[k*RENAMED_OP_W +: RENAMED_OP_W]),
            .old_alias   (slot_old[k*PR_ADDR_W +: PR_ADDR_W]),
            .slot_valid  (valid_chain[k+1])
        );
    end

    // buffer counts as free if every still pending slot hands off this cycle
    assign pending_next = out_pending_q & ~(out_pending_q & renamed_ready);

    // last slot valid means the pool had a register for each of the four
    assign do_rename   = valid_chain[RENAME_WIDTH] && (pending_next == '0);
    assign group_ready = !grp_valid_q || do_rename;
    assign group_take  = group_valid && group_ready;

    assign alias_next = do_rename ? alias_chain[RENAME_WIDTH] : alias_cur;

    always_comb begin
        done_next = do_rename ? done_chain[RENAME_WIDTH] : done_cur;
        for (int i = 0; i < N_CMPLT; i++) begin
            if (cmplt_valid[i]) begin
                done_next[cmplt_phys[i*PR_ADDR_W +: PR_ADDR_W]] = 1'b1;
            end
        end
    end

    // widened to all physical registers so reserved ones simply fall off
    assign pool_view = {pool_q, {RESERVED_REGS{1'b0}}};

    always_comb begin
        logic [PHYS_REGS-1:0] merged;
        merged = {do_rename ? pool_chain[RENAME_WIDTH] : pool_q, {RESERVED_REGS{1'b0}}};
        for (int i = 0; i < N_FREE; i++) begin
            if (free_valid[i]) begin
                merged[free_phys[i*PR_ADDR_W +: PR_ADDR_W]] = 1'b1;
            end
        end
        pool_next = merged[PHYS_REGS-1:RESERVED_REGS];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grp_valid_q   <= 1'b0;
            pool_q        <= '1;
            out_pending_q <= '0;
        end else begin
            if (group_take) begin
                grp_valid_q <= 1'b1;
            end else if (do_rename) begin
                grp_valid_q <= 1'b0;
            end
            pool_q        <= pool_next;
            out_pending_q <= do_rename ? {RENAME_WIDTH{1'b1}} : pending_next;
        end
    end

    always_ff @(posedge clk) begin
        if (group_take) begin
            grp_ops_q  <= group_ops;
            grp_tags_q <= rob_tags;
        end
        if (do_rename) begin
            out_ops_q <= slot_ops;
            out_old_q <= slot_old;
        end
    end

    assign renamed_ops       = out_ops_q;
    assign renamed_old_alias = out_old_q;
    assign renamed_valid     = out_pending_q;

    // a committed old alias must be outstanding, never already free
    for (genvar f = 0; f < N_FREE; f++) begin : g_free_chk
        a_no_double_free : assert property (
            @(posedge clk) disable iff (rst)
            free_valid[f] |-> !pool_view[free_phys[f*PR_ADDR_W +: PR_ADDR_W]]
        ) else $error("rename_stage: free of p%0d which is already in the pool",
                      free_phys[f*PR_ADDR_W +: PR_ADDR_W]);
    end

endmodule

`default_nettype wire

// ==== rtl/rename_slot.sv ====
/* One rename lane. Views coming in already carry the allocations of earlier slots in the
   same group, so intra-group dependencies resolve here. */
`default_nettype none

module rename_slot (
    input  rename_pkg::micro_op_u                           op,
    input  logic [rename_pkg::ROB_TAG_W-1:0]                rob_tag,
    input  logic [rename_pkg::POOL_W-1:0]                   pool_in,
    input  logic [rename_pkg::ALIAS_W-1:0]                  alias_in,
    input  logic [rename_pkg::PHYS_REGS-1:0]                done_in,
    input  logic                                            prev_valid,
    input  logic [rename_pkg::N_CMPLT*rename_pkg::PR_ADDR_W-1:0] cmplt_phys,
    input  logic [rename_pkg::N_CMPLT-1:0]                  cmplt_valid,
    output logic [rename_pkg::POOL_W-1:0]                   pool_out,
    output logic [rename_pkg::ALIAS_W-1:0]                  alias_out,
    output logic [rename_pkg::PHYS_REGS-1:0]                done_out,
    output logic [rename_pkg::RENAMED_OP_W-1:0]             renamed_op,
    output logic [rename_pkg::PR_ADDR_W-1:0]                old_alias,
    output logic                                            slot_valid
);

    import rename_pkg::*;

    logic [PR_ADDR_W-1:0] src_a_phys;
    logic                 src_a_ready;
    logic [PR_ADDR_W-1:0] src_b_phys;
    logic                 src_b_ready;
    logic [IMM_W-1:0]     imm;
    logic [PR_ADDR_W-1:0] dst_phys;

    // sources see the table before this slot's own destination is written
    rename_operand_decoder i_decoder (
        .op          (op),
        .alias_view  (alias_in),
        .done_view   (done_in),
        .cmplt_phys  (cmplt_phys),
        .cmplt_valid (cmplt_valid),
        .src_a_phys  (src_a_phys),
        .src_a_ready (src_a_ready),
        .src_b_phys  (src_b_phys),
        .src_b_ready (src_b_ready),
        .imm         (imm)
    );

    rename_allocator i_allocator (
        .op         (op),
        .pool_in    (pool_in),
        .alias_in   (alias_in),
        .done_in    (done_in),
        .prev_valid (prev_valid),
        .pool_out   (pool_out),
        .alias_out  (alias_out),
        .done_out   (done_out),
        .dst_phys   (dst_phys),
        .old_alias  (old_alias),
        .slot_valid (slot_valid)
    );

    always_comb begin
        renamed_op = '0;
        renamed_op[OFF_ARCH_DST  +: ARCH_W]    = op.rf.dst;
        renamed_op[OFF_OPCODE    +: OPCODE_W]  = op.rf.opcode;
        renamed_op[OFF_ROB_TAG   +: ROB_TAG_W] = rob_tag;
        renamed_op[OFF_DST_PHYS  +: PR_ADDR_W] = dst_phys;
        renamed_op[OFF_SRC_A     +: PR_ADDR_W] = src_a_phys;
        renamed_op[OFF_SRC_A_RDY]              = src_a_ready;
        renamed_op[OFF_SRC_B     +: PR_ADDR_W] = src_b_phys;
        renamed_op[OFF_SRC_B_RDY]              = src_b_ready;
        renamed_op[OFF_IMM       +: IMM_W]     = imm;
    end

endmodule

`default_nettype wire

// ==== rtl/rename_allocator.sv ====
/* Destination allocation for one slot. Takes the lowest free register; with an empty pool or
   no upstream valid the views pass through untouched. */
`default_nettype none

module rename_allocator (
    input  rename_pkg::micro_op_u                   op,
    input  logic [rename_pkg::POOL_W-1:0]           pool_in,
    input  logic [rename_pkg::ALIAS_W-1:0]          alias_in,
    input  logic [rename_pkg::PHYS_REGS-1:0]        done_in,
    input  logic                                    prev_valid,
    output logic [rename_pkg::POOL_W-1:0]           pool_out,
    output logic [rename_pkg::ALIAS_W-1:0]          alias_out,
    output logic [rename_pkg::PHYS_REGS-1:0]        done_out,
    output logic [rename_pkg::PR_ADDR_W-1:0]        dst_phys,
    output logic [rename_pkg::PR_ADDR_W-1:0]        old_alias,
    output logic                                    slot_valid
);

    import rename_pkg::*;

    logic [PR_ADDR_W-1:0] pick;

    // priority scan from the top, so the lowest set bit wins
    always_comb begin
        pick = '0;
        for (int i = POOL_W - 1; i >= 0; i--) begin
            if (pool_in[i]) begin
                pick = PR_ADDR_W'(i);
            end
        end
    end

    // pool bit i stands for physical register i + 2
    assign dst_phys   = pick + PR_ADDR_W'(RESERVED_REGS);
    assign old_alias  = alias_in[op.rf.dst*PR_ADDR_W +: PR_ADDR_W];
    assign slot_valid = prev_valid && (pool_in != '0);

    always_comb begin
        pool_out  = pool_in;
        alias_out = alias_in;
        done_out  = done_in;
        if (slot_valid) begin
            pool_out[pick]                             = 1'b0;
            done_out[dst_phys]                         = 1'b0;
            alias_out[op.rf.dst*PR_ADDR_W +: PR_ADDR_W] = dst_phys;
        end
    end

    // decode only produces destinations that exist in the alias table
    always_comb begin
        if (prev_valid) begin
            a_dst_in_range : assert (int'(op.rf.dst) < ARCH_REGS)
                else $error("rename_allocator: destination r%0d outside alias table",
                            op.rf.dst);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_operand_decoder.sv ====
/* Source lookup for one micro-op. Sources outside the alias table read as register 0;
   immediate form returns a ready register 0 for src_b. */
`default_nettype none

module rename_operand_decoder (
    input  rename_pkg::micro_op_u                           op,
    input  logic [rename_pkg::ALIAS_W-1:0]                  alias_view,
    input  logic [rename_pkg::PHYS_REGS-1:0]                done_view,
    input  logic [rename_pkg::N_CMPLT*rename_pkg::PR_ADDR_W-1:0] cmplt_phys,
    input  logic [rename_pkg::N_CMPLT-1:0]                  cmplt_valid,
    output logic [rename_pkg::PR_ADDR_W-1:0]                src_a_phys,
    output logic                                            src_a_ready,
    output logic [rename_pkg::PR_ADDR_W-1:0]                src_b_phys,
    output logic                                            src_b_ready,
    output logic [rename_pkg::IMM_W-1:0]                    imm
);

    import rename_pkg::*;

    logic imm_form;

    function automatic logic [PR_ADDR_W-1:0] lookup(input logic [ARCH_W-1:0] arch,
                                                    input logic [ALIAS_W-1:0] view);
        if (int'(arch) >= ARCH_REGS) begin
            return '0;
        end
        return view[arch*PR_ADDR_W +: PR_ADDR_W];
    endfunction

    // done flag, or a completion landing this cycle, or the zero register
    function automatic logic is_ready(input logic [PR_ADDR_W-1:0] phys,
                                      input logic [PHYS_REGS-1:0] done,
                                      input logic [N_CMPLT*PR_ADDR_W-1:0] c_phys,
                                      input logic [N_CMPLT-1:0] c_valid);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < N_CMPLT; i++) begin
            if (c_valid[i] && c_phys[i*PR_ADDR_W +: PR_ADDR_W] == phys) begin
                hit = 1'b1;
            end
        end
        return done[phys] || hit || (phys == '0);
    endfunction

    assign imm_form = is_imm_form(op.rf.opcode);

    always_comb begin
        src_a_phys  = lookup(op.rf.src_a, alias_view);
        src_a_ready = is_ready(src_a_phys, done_view, cmplt_phys, cmplt_valid);
        if (imm_form) begin
            src_b_phys  = '0;
            src_b_ready = 1'b1;
            imm         = op.imf.imm;
        end else begin
            src_b_phys  = lookup(op.rf.src_b, alias_view);
            src_b_ready = is_ready(src_b_phys, done_view, cmplt_phys, cmplt_valid);
            imm         = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_rat.sv ====
/* Register alias table and done flags. After reset every architectural register aliases
   physical register 0 and every done flag is set. */
`default_nettype none

module rename_rat (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [rename_pkg::ALIAS_W-1:0]      alias_next,
    input  logic [rename_pkg::PHYS_REGS-1:0]    done_next,
    output logic [rename_pkg::ALIAS_W-1:0]      alias_cur,
    output logic [rename_pkg::PHYS_REGS-1:0]    done_cur
);

    logic [rename_pkg::ALIAS_W-1:0]   alias_q;
    logic [rename_pkg::PHYS_REGS-1:0] done_q;

    // the stage presents the full next state every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            alias_q <= '0;
            done_q  <= '1;
        end else begin
            alias_q <= alias_next;
            done_q  <= done_next;
        end
    end

    assign alias_cur = alias_q;
    assign done_cur  = done_q;

    // reserved registers are never allocated, so nothing may ever clear their flags
    a_reserved_done : assert property (
        @(posedge clk) disable iff (rst)
        done_cur[1:0] == 2'b11
    ) else $error("rename_rat: reserved register lost its done flag");

endmodule

`default_nettype wire

// ==== rtl/rename_pkg.sv ====
/* Widths and encodings shared by the rename stage. Rename width is fixed at four slots;
   physical registers 0 and 1 are reserved and never enter the free pool. */
`default_nettype none

package rename_pkg;

    localparam int RENAME_WIDTH  = 4;
    localparam int ARCH_REGS     = 10;
    localparam int ARCH_W        = 4;
    localparam int PHYS_REGS     = 32;
    localparam int PR_ADDR_W     = 5;
    localparam int RESERVED_REGS = 2;
    localparam int POOL_W        = PHYS_REGS - RESERVED_REGS;
    localparam int ROB_TAG_W     = 5;
    localparam int N_CMPLT       = 4;
    localparam int N_FREE        = 4;
    localparam int OPCODE_W      = 4;
    localparam int IMM_W         = 12;
    localparam int MICRO_OP_W    = 24;
    localparam int RENAMED_OP_W  = 42;

    // flat alias table, one PR_ADDR_W field per architectural register
    localparam int ALIAS_W = ARCH_REGS * PR_ADDR_W;

    // renamed-op field offsets, counted up from bit 0
    localparam int OFF_IMM       = 0;
    localparam int OFF_SRC_B_RDY = OFF_IMM + IMM_W;
    localparam int OFF_SRC_B     = OFF_SRC_B_RDY + 1;
    localparam int OFF_SRC_A_RDY = OFF_SRC_B + PR_ADDR_W;
    localparam int OFF_SRC_A     = OFF_SRC_A_RDY + 1;
    localparam int OFF_DST_PHYS  = OFF_SRC_A + PR_ADDR_W;
    localparam int OFF_ROB_TAG   = OFF_DST_PHYS + PR_ADDR_W;
    localparam int OFF_OPCODE    = OFF_ROB_TAG + ROB_TAG_W;
    localparam int OFF_ARCH_DST  = OFF_OPCODE + OPCODE_W;

    // one micro-op word, read either as register form or as immediate form
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [ARCH_W-1:0]   dst;
            logic [ARCH_W-1:0]   src_a;
            logic [ARCH_W-1:0]   src_b;
            logic [MICRO_OP_W-OPCODE_W-3*ARCH_W-1:0] unused;
        } rf;
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [ARCH_W-1:0]   dst;
            logic [ARCH_W-1:0]   src_a;
            logic [IMM_W-1:0]    imm;
        } imf;
    } micro_op_u;

    // top opcode bit selects immediate form
    function automatic logic is_imm_form(input logic [OPCODE_W-1:0] opcode);
        return opcode[OPCODE_W-1];
    endfunction

endpackage

`default_nettype wire
